// ==== source/cache_types.sv ====
package cache_types;

    //////////////////////////////
    // cache geometry
    //////////////////////////////

    localparam int num_ways    = 4;
    localparam int num_sets    = 16;
    localparam int set_bits    = 4;
    localparam int offset_bits = 3;
    localparam int tag_bits    = 23;
    localparam int line_bits   = 256;
    localparam int line_bytes  = 32;

    //////////////////////////////
    // request and FSM encodings
    //////////////////////////////

    typedef enum logic [1:0] {
        none,
        read,
        write
    } req_t;

    typedef enum logic [2:0] {
        idle,
        compare,
        writemem,
        readmem,
        writeback,
        sramstall
    } process_state_t;

    //////////////////////////////
    // address and storage views
    //////////////////////////////

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set;
        logic [offset_bits-1:0] word_off;
        logic [1:0]             byte_off;
    } cache_addr_t;

    typedef struct packed {
        logic                dirty;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    // request as held between decode and process
    typedef struct packed {
        req_t        req;
        cache_addr_t addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
        logic        queued;
    } stage_t;

    // bit 0 root, bit 1 left pair, bit 2 right pair
    typedef logic [2:0] plru_t;

endpackage

// ==== source/cache_data_array.sv ====
module cache_data_array (
    input  logic                               clk,
    input  logic                               csb,
    input  logic                               web,
    input  logic [cache_types::line_bytes-1:0] wmask,
    input  logic [cache_types::set_bits-1:0]   addr,
    input  logic [cache_types::line_bits-1:0]  din,
    output logic [cache_types::line_bits-1:0]  dout
);
    import cache_types::*;

    logic [line_bits-1:0] mem [num_sets];
    logic [line_bits-1:0] merged;

    // masked bytes from din, rest from the stored line
    always_comb begin
        merged = mem[addr];
        for (int b = 0; b < line_bytes; b++) begin
            if (wmask[b]) merged[8*b +: 8] = din[8*b +: 8];
        end
    end

    // active low select and write enable
    always_ff @(posedge clk) begin
        if (!csb) begin
            if (!web) begin
                mem[addr] <= merged;
                // written line shows up on the read port
                dout      <= merged;
            end else begin
                dout <= mem[addr];
            end
        end
    end

endmodule

// ==== source/cache_tag_array.sv ====
module cache_tag_array (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             csb,
    input  logic                             web,
    input  logic [cache_types::set_bits-1:0] addr,
    input  cache_types::tag_entry_t          din,
    output cache_types::tag_entry_t          dout,
    output logic                             valid
);
    import cache_types::*;

    tag_entry_t          mem [num_sets];
    logic [num_sets-1:0] valid_bits;

    // tag storage
    always_ff @(posedge clk) begin
        if (!csb) begin
            if (!web) begin
                mem[addr] <= din;
                dout      <= din;
            end else begin
                dout <= mem[addr];
            end
        end
    end

    // valid bits, any write marks the entry valid
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            valid      <= 1'b0;
        end else if (!csb) begin
            if (!web) begin
                valid_bits[addr] <= 1'b1;
                valid            <= 1'b1;
            end else begin
                valid <= valid_bits[addr];
            end
        end
    end

endmodule

// ==== source/lru_array.sv ====
module lru_array (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             rd_en,
    input  logic [cache_types::set_bits-1:0] rd_set,
    output cache_types::plru_t               rd_state,
    input  logic                             wr_en,
    input  logic [cache_types::set_bits-1:0] wr_set,
    input  cache_types::plru_t               wr_state
);
    import cache_types::*;

    plru_t mem [num_sets];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                mem[s] <= '0;
            end
            rd_state <= '0;
        end else begin
            if (wr_en) begin
                mem[wr_set] <= wr_state;
            end
            // same-set update forwarded to the read
            if (rd_en) begin
                rd_state <= (wr_en && (wr_set == rd_set)) ? wr_state : mem[rd_set];
            end
        end
    end

endmodule

// ==== source/lru_ctrl.sv ====
module lru_ctrl (
    input  cache_types::plru_t state,
    input  logic [1:0]         access_way,
    output logic [1:0]         victim_way,
    output cache_types::plru_t next_state
);

    // root 0 picks ways 0/1, root 1 picks ways 2/3
    always_comb begin
        if (!state[0]) begin
            victim_way = {1'b0, state[1]};
        end else begin
            victim_way = {1'b1, state[2]};
        end
    end

    // point root and pair bit away from the accessed way
    always_comb begin
        next_state    = state;
        next_state[0] = ~access_way[1];
        if (!access_way[1]) begin
            next_state[1] = ~access_way[0];
        end else begin
            next_state[2] = ~access_way[0];
        end
    end

endmodule

// ==== source/cache.sv ====
module cache (
    input  logic         clk,
    input  logic         rst,

    // cpu side
    input  logic [31:0]  ufp_addr,
    input  logic [3:0]   ufp_rmask,
    input  logic [3:0]   ufp_wmask,
    input  logic [31:0]  ufp_wdata,
    output logic [31:0]  ufp_rdata,
    output logic         ufp_resp,

    // memory side, whole lines
    output logic [31:0]  dfp_addr,
    output logic         dfp_read,
    output logic         dfp_write,
    output logic [255:0] dfp_wdata,
    input  logic [255:0] dfp_rdata,
    input  logic         dfp_resp
);
    import cache_types::*;

    // array read ports
    logic [line_bits-1:0]  data_rd     [num_ways];
    tag_entry_t            tag_rd      [num_ways];
    logic                  valid_rd    [num_ways];

    // array write side
    logic                  array_web   [num_ways];
    logic [line_bytes-1:0] data_wmask  [num_ways];
    logic [line_bits-1:0]  data_din;
    tag_entry_t            tag_din;
    logic [line_bytes-1:0] byte_mask;
    logic [set_bits-1:0]   sram_set;
    logic                  sram_csb;
    logic                  use_stage;

    //////////////////////////////
    // decode stage
    //////////////////////////////

    req_t        new_req;
    cache_addr_t in_addr;
    stage_t      stage_d;
    logic        update_array;

    assign in_addr = cache_addr_t'(ufp_addr);

    // write mask wins if both are set
    always_comb begin
        new_req = none;
        if (ufp_rmask != 4'b0) new_req = read;
        if (ufp_wmask != 4'b0) new_req = write;
    end

    always_comb begin
        stage_d.req    = new_req;
        stage_d.addr   = in_addr;
        stage_d.wdata  = ufp_wdata;
        stage_d.wmask  = ufp_wmask;
        // arrays busy with a write this cycle, so the read is deferred
        stage_d.queued = (new_req != none) && update_array;
    end

    //////////////////////////////
    // stage register
    //////////////////////////////

    stage_t stg;
    logic   stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            stg.req    <= none;
            stg.queued <= 1'b0;
        end else if (!stall) begin
            stg <= stage_d;
        end
    end

    //////////////////////////////
    // process stage
    //////////////////////////////

    process_state_t state;
    process_state_t state_next;
    logic           hit;
    logic           evict;
    logic           serve;
    logic           hit_write;
    logic           fill;
    logic           victim_dirty;
    logic [1:0]     access_way;
    logic [1:0]     victim_way;
    logic [31:0]    victim_addr;
    logic [31:0]    fill_addr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: state_next = compare;
            compare: begin
                if (evict) begin
                    state_next = writemem;
                end else if ((stg.req != none) && !hit) begin
                    state_next = readmem;
                end else if (hit_write) begin
                    state_next = sramstall;
                end
            end
            writemem: if (dfp_resp) state_next = readmem;
            readmem: if (dfp_resp) state_next = writeback;
            writeback: begin
                if (hit) state_next = hit_write ? sramstall : compare;
            end
            sramstall: state_next = compare;
            default: state_next = idle;
        endcase
    end

    assign victim_dirty = tag_rd[victim_way].dirty && valid_rd[victim_way];
    assign victim_addr  = {tag_rd[victim_way].tag, stg.addr.set, 5'b0};
    assign fill_addr    = {stg.addr.tag, stg.addr.set, 5'b0};

    // strobes, responses and stall
    always_comb begin
        stall     = 1'b0;
        serve     = 1'b0;
        evict     = 1'b0;
        fill      = 1'b0;
        dfp_read  = 1'b0;
        dfp_write = 1'b0;
        dfp_addr  = fill_addr;
        case (state)
            compare: begin
                if (stg.req != none) begin
                    if (hit) begin
                        serve = 1'b1;
                    end else begin
                        stall = 1'b1;
                        if (victim_dirty) begin
                            evict     = 1'b1;
                            dfp_write = 1'b1;
                            dfp_addr  = victim_addr;
                        end else begin
                            dfp_read = 1'b1;
                        end
                    end
                end
            end
            writemem: begin
                stall     = 1'b1;
                dfp_write = 1'b1;
                dfp_addr  = victim_addr;
            end
            readmem: begin
                stall    = 1'b1;
                dfp_read = 1'b1;
                fill     = dfp_resp;
            end
            // refilled line is visible on the read ports here
            writeback: begin
                if (hit) serve = 1'b1;
                else stall = 1'b1;
            end
            sramstall: stall = (stg.req != none);
            default: stall = 1'b0;
        endcase
        ufp_resp     = serve;
        hit_write    = serve && (stg.req == write);
        update_array = fill || hit_write;
    end

    assign dfp_wdata = data_rd[victim_way];
    assign ufp_rdata = data_rd[access_way][{stg.addr.word_off, 5'b0} +: 32];

    // hit detection
    always_comb begin
        hit        = 1'b0;
        access_way = 2'd0;
        if (stg.req != none) begin
            for (int i = 0; i < num_ways; i++) begin
                if (valid_rd[i] && (tag_rd[i].tag == stg.addr.tag)) begin
                    hit        = 1'b1;
                    access_way = 2'(i);
                end
            end
        end
    end

    //////////////////////////////
    // SRAM control
    //////////////////////////////

    assign byte_mask = line_bytes'(stg.wmask) << {stg.addr.word_off, 2'b00};
    assign data_din  = fill ? dfp_rdata : {8{stg.wdata}};
    assign tag_din   = '{dirty: !fill, tag: stg.addr.tag};

    // only one way written per cycle
    always_comb begin
        for (int i = 0; i < num_ways; i++) begin
            array_web[i]  = 1'b1;
            data_wmask[i] = '0;
        end
        if (fill) begin
            array_web[victim_way]  = 1'b0;
            data_wmask[victim_way] = '1;
        end else if (hit_write) begin
            array_web[access_way]  = 1'b0;
            data_wmask[access_way] = byte_mask;
        end
    end

    // stage set while writing or holding a deferred read
    assign use_stage = update_array || (stg.queued && stall);
    assign sram_set  = use_stage ? stg.addr.set : in_addr.set;
    assign sram_csb  = ~(~stall | update_array | stg.queued);

    for (genvar i = 0; i < num_ways; i++) begin : ways
        cache_data_array data_array (
            .clk   (clk),
            .csb   (sram_csb),
            .web   (array_web[i]),
            .wmask (data_wmask[i]),
            .addr  (sram_set),
            .din   (data_din),
            .dout  (data_rd[i])
        );

        cache_tag_array tag_array (
            .clk   (clk),
            .rst   (rst),
            .csb   (sram_csb),
            .web   (array_web[i]),
            .addr  (sram_set),
            .din   (tag_din),
            .dout  (tag_rd[i]),
            .valid (valid_rd[i])
        );
    end

    //////////////////////////////
    // replacement
    //////////////////////////////

    plru_t lru_state;
    plru_t lru_next;

    lru_ctrl lru_ctrl (
        .state      (lru_state),
        .access_way (access_way),
        .victim_way (victim_way),
        .next_state (lru_next)
    );

    // read on request arrival, update on every response
    lru_array lru_array (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (new_req != none),
        .rd_set   (in_addr.set),
        .rd_state (lru_state),
        .wr_en    (ufp_resp),
        .wr_set   (stg.addr.set),
        .wr_state (lru_next)
    );

endmodule

// ==== sim/cache_assertions.sv ====
module cache_assertions (
    input logic        clk,
    input logic        rst,
    input logic [31:0] dfp_addr,
    input logic        dfp_read,
    input logic        dfp_write,
    input logic        dfp_resp,
    input logic        ufp_resp
);

    // number of assertion failures so far
    int fail_count = 0;

    // memory port moves one direction at a time
    no_read_and_write: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else begin
            fail_count++;
            $error("dfp_read and dfp_write are high together");
        end

    line_aligned: assert property (@(posedge clk) disable iff (rst)
        (dfp_read || dfp_write) |-> (dfp_addr[4:0] == 5'b0))
        else begin
            fail_count++;
            $error("dfp_addr is not line aligned: %h", dfp_addr);
        end

    // strobe and address hold until the memory answers
    read_held: assert property (@(posedge clk) disable iff (rst)
        (dfp_read && !dfp_resp) |=> (dfp_read && $stable(dfp_addr)))
        else begin
            fail_count++;
            $error("dfp_read dropped or dfp_addr moved before dfp_resp");
        end

    write_held: assert property (@(posedge clk) disable iff (rst)
        (dfp_write && !dfp_resp) |=> (dfp_write && $stable(dfp_addr)))
        else begin
            fail_count++;
            $error("dfp_write dropped or dfp_addr moved before dfp_resp");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !ufp_resp)
        else begin
            fail_count++;
            $error("ufp_resp high in the cycle after reset");
        end

endmodule

// ==== sim/cache_tb.sv ====
module cache_tb;
    import cache_types::*;

    localparam int period       = 40;
    localparam int seed         = 99081;
    localparam int delay_min    = 1;
    localparam int delay_max    = 6;
    localparam int mem_lines    = 256;
    localparam int resp_limit   = 40;
    localparam int num_rows     = 20;
    localparam int watchdog_time = num_rows * 40 * period;

    typedef struct packed {
        req_t        kind;
        logic [31:0] addr;
        logic [3:0]  rmask;
        logic [3:0]  wmask;
        logic [31:0] wdata;
        logic        wb;
    } row_t;

    // kind, address, rmask, wmask, wdata, expect writeback
    row_t rows [num_rows] = '{
        '{read,  32'h0000_0228, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_0234, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_0220, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{write, 32'h0000_0228, 4'h0, 4'h5, 32'ha5a5_5a5a, 1'b0},
        '{read,  32'h0000_0228, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{write, 32'h0000_023c, 4'h0, 4'h8, 32'h1234_5678, 1'b0},
        '{read,  32'h0000_023c, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_0220, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_0224, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_0228, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_022c, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_0264, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{write, 32'h0000_0464, 4'h0, 4'hf, 32'hc0ff_ee01, 1'b0},
        '{read,  32'h0000_0660, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_086c, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{write, 32'h0000_0270, 4'h0, 4'h3, 32'h0000_beef, 1'b0},
        '{read,  32'h0000_0a64, 4'hf, 4'h0, 32'h0000_0000, 1'b1},
        '{read,  32'h0000_0c68, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_0464, 4'hf, 4'h0, 32'h0000_0000, 1'b0},
        '{read,  32'h0000_0270, 4'hf, 4'h0, 32'h0000_0000, 1'b0}
    };

    logic         clk;
    logic         rst;
    logic [31:0]  ufp_addr;
    logic [3:0]   ufp_rmask;
    logic [3:0]   ufp_wmask;
    logic [31:0]  ufp_wdata;
    logic [31:0]  ufp_rdata;
    logic         ufp_resp;
    logic [31:0]  dfp_addr;
    logic         dfp_read;
    logic         dfp_write;
    logic [255:0] dfp_wdata;
    logic [255:0] dfp_rdata;
    logic         dfp_resp;

    cache UUT (.*);

    bind cache cache_assertions checks (
        .clk       (clk),
        .rst       (rst),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_resp  (dfp_resp),
        .ufp_resp  (ufp_resp)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    //////////////////////////////
    // memory model
    //////////////////////////////

    logic [255:0] mem [mem_lines];
    logic [31:0]  rng;
    int           rd_total;
    int           wr_total;
    logic [31:0]  rd_addr;
    logic [31:0]  wr_addr;
    logic [255:0] wr_line;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    initial begin : memory_model
        logic [31:0] req_addr;
        logic [7:0]  line;
        int          delay;
        dfp_resp  = 1'b0;
        dfp_rdata = '0;
        rd_total  = 0;
        wr_total  = 0;
        rng       = seed;
        for (int i = 0; i < mem_lines; i++) begin
            for (int w = 0; w < 8; w++) begin
                mem[i][32*w +: 32] = xorshift();
            end
        end
        @(negedge clk);
        forever begin
            if (dfp_read || dfp_write) begin
                req_addr = dfp_addr;
                line     = dfp_addr[12:5];
                delay    = delay_min + int'(xorshift() % (delay_max - delay_min + 1));
                repeat (delay) @(negedge clk);
                if (dfp_write) begin
                    mem[line] = dfp_wdata;
                    wr_addr   = req_addr;
                    wr_line   = dfp_wdata;
                    wr_total++;
                end else begin
                    dfp_rdata = mem[line];
                    rd_addr   = req_addr;
                    rd_total++;
                end
                dfp_resp = 1'b1;
                @(negedge clk);
                dfp_resp = 1'b0;
            end else begin
                @(negedge clk);
            end
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////

    logic [255:0]        gold [mem_lines];
    logic [tag_bits-1:0] ref_tag   [num_sets][num_ways];
    bit                  ref_valid [num_sets][num_ways];
    bit                  ref_dirty [num_sets][num_ways];
    plru_t               ref_plru  [num_sets];

    logic         exp_hit;
    logic         exp_wb;
    logic [31:0]  exp_wb_addr;
    logic [255:0] exp_wb_line;
    logic [31:0]  exp_fill_addr;
    logic [31:0]  exp_rdata;

    // tree walk, root then pair bit
    function automatic logic [1:0] pick_victim(input plru_t p);
        return p[0] ? (p[2] ? 2'd3 : 2'd2) : (p[1] ? 2'd1 : 2'd0);
    endfunction

    function automatic plru_t touch(input plru_t p, input logic [1:0] way);
        plru_t n;
        n = p;
        case (way)
            2'd0: begin n[0] = 1'b1; n[1] = 1'b1; end
            2'd1: begin n[0] = 1'b1; n[1] = 1'b0; end
            2'd2: begin n[0] = 1'b0; n[2] = 1'b1; end
            default: begin n[0] = 1'b0; n[2] = 1'b0; end
        endcase
        return n;
    endfunction

    function automatic logic [31:0] expand_mask(input logic [3:0] m);
        return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
    endfunction

    task automatic step_model(input int k);
        cache_addr_t a;
        logic [7:0]  idx;
        int          hit_way;
        logic [1:0]  way;
        a       = cache_addr_t'(rows[k].addr);
        idx     = rows[k].addr[12:5];
        hit_way = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (ref_valid[a.set][w] && (ref_tag[a.set][w] == a.tag)) hit_way = w;
        end
        exp_hit       = (hit_way >= 0);
        exp_wb        = 1'b0;
        exp_fill_addr = {a.tag, a.set, 5'b0};
        if (exp_hit) begin
            way = 2'(hit_way);
        end else begin
            way         = pick_victim(ref_plru[a.set]);
            exp_wb      = ref_valid[a.set][way] && ref_dirty[a.set][way];
            exp_wb_addr = {ref_tag[a.set][way], a.set, 5'b0};
            exp_wb_line = gold[exp_wb_addr[12:5]];
            ref_tag[a.set][way]   = a.tag;
            ref_valid[a.set][way] = 1'b1;
            ref_dirty[a.set][way] = 1'b0;
        end
        if (rows[k].kind == write) begin
            for (int b = 0; b < 4; b++) begin
                if (rows[k].wmask[b]) begin
                    gold[idx][32*a.word_off + 8*b +: 8] = rows[k].wdata[8*b +: 8];
                end
            end
            ref_dirty[a.set][way] = 1'b1;
        end
        exp_rdata        = gold[idx][32*a.word_off +: 32];
        ref_plru[a.set] = touch(ref_plru[a.set], way);
    endtask

    //////////////////////////////
    // checks and stimulus
    //////////////////////////////

    int errors;
    int rd_before;
    int wr_before;
    int lat;
    int rows_done;
    bit prev_write;
    bit timed_out;

    task automatic check_equal(input string name, input logic [255:0] exp,
                               input logic [255:0] got);
        assert (exp === got) else begin
            $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic drive_row(input int k);
        ufp_addr  = rows[k].addr;
        ufp_rmask = rows[k].rmask;
        ufp_wmask = rows[k].wmask;
        ufp_wdata = rows[k].wdata;
    endtask

    task automatic check_row(input int k, input int cycles);
        int reads;
        int writes;
        logic [31:0] m;
        reads  = rd_total - rd_before;
        writes = wr_total - wr_before;
        m      = expand_mask(rows[k].rmask);
        assert (exp_wb == rows[k].wb) else begin
            $display("row %0d: reference model and table disagree on the writeback", k);
            errors++;
        end
        check_equal("dfp_write count", 256'(rows[k].wb ? 1 : 0), 256'(writes));
        if (exp_hit) begin
            check_equal("hit latency", 256'(prev_write ? 2 : 1), 256'(cycles));
            check_equal("dfp_read count", 256'(0), 256'(reads));
        end else begin
            check_equal("dfp_read count", 256'(1), 256'(reads));
            if (reads == 1) check_equal("dfp_addr (read)", 256'(exp_fill_addr), 256'(rd_addr));
        end
        if (exp_wb && writes == 1) begin
            check_equal("dfp_addr (write)", 256'(exp_wb_addr), 256'(wr_addr));
            check_equal("dfp_wdata", exp_wb_line, wr_line);
        end
        if (rows[k].kind == read) begin
            check_equal("ufp_rdata", 256'(exp_rdata & m), 256'(ufp_rdata & m));
        end
    endtask

    initial begin
        rst        = 1'b1;
        ufp_addr   = '0;
        ufp_rmask  = '0;
        ufp_wmask  = '0;
        ufp_wdata  = '0;
        errors     = 0;
        rows_done  = 0;
        prev_write = 1'b0;
        timed_out  = 1'b0;
        for (int s = 0; s < num_sets; s++) begin
            ref_plru[s] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < mem_lines; i++) begin
            gold[i] = mem[i];
        end
        repeat (2) @(negedge clk);
        // each request goes out in the cycle of the previous response
        for (int k = 0; k < num_rows; k++) begin
            step_model(k);
            rd_before = rd_total;
            wr_before = wr_total;
            drive_row(k);
            @(negedge clk);
            lat       = 1;
            ufp_rmask = '0;
            ufp_wmask = '0;
            while (!ufp_resp && lat < resp_limit) begin
                @(negedge clk);
                lat++;
            end
            assert (ufp_resp) else begin
                $display("row %0d got no response within %0d cycles", k, resp_limit);
                errors++;
                timed_out = 1'b1;
            end
            if (timed_out) break;
            check_row(k, lat);
            prev_write = (rows[k].kind == write);
            rows_done++;
        end
        repeat (4) @(negedge clk);
        // bound assertion failures count as errors too
        errors += UUT.checks.fail_count;
        $display("rows run: %0d of %0d, errors: %0d", rows_done, num_rows, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(watchdog_time);
        $display("watchdog expired after %0d time units, errors: %0d", watchdog_time, errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
source/cache_types.sv
source/cache_data_array.sv
source/cache_tag_array.sv
source/lru_array.sv
source/lru_ctrl.sv
source/cache.sv
sim/cache_assertions.sv
sim/cache_tb.sv

// ==== Makefile ====
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

SOURCES := $(wildcard source/*.sv) $(wildcard sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
